/* Bender.yml */
package:
  name: rv64i_core

sources:
  - files:
      - rtl/rv_isa_pkg.sv
      - rtl/pipe_pkg.sv
      - rtl/fetch_unit.sv
      - rtl/decode_stage.sv
      - rtl/register_file.sv
      - rtl/execute_stage.sv
      - rtl/result_stage.sv
      - rtl/rv_core_top.sv

  - target: test
    files:
      - bench/core_props.sv
      - bench/core_checker.sv
      - bench/core_tb.sv

/* bench/core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module core_checker #(
    parameter int                PROG_WORDS = 200,
    parameter rv_isa_pkg::xlen_t RESET_PC   = '0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_isa_pkg::inst_t     prog_mem [PROG_WORDS],
    input  logic                  retire_valid,
    input  rv_isa_pkg::xlen_t     retire_pc,
    input  rv_isa_pkg::reg_addr_t retire_rd,
    input  rv_isa_pkg::xlen_t     retire_data,
    output logic                  done,
    output int                    retired,
    output int                    pc_errors,
    output int                    rd_errors,
    output int                    data_errors
);
    import rv_isa_pkg::*;

    localparam xlen_t HALT_PC = RESET_PC + 4 * (PROG_WORDS - 1);

    // Architectural effect of one instruction
    typedef struct packed {
        reg_addr_t rd;        // zero when nothing is written
        xlen_t     value;
        xlen_t     next_pc;
    } step_t;

    xlen_t model_regs [32];
    xlen_t model_pc;
    step_t exp_step;

    function automatic inst_t word_at(xlen_t pc);
        xlen_t idx;
        idx = (pc - RESET_PC) >> 2;
        if (pc < RESET_PC || idx >= PROG_WORDS) begin
            return prog_mem[PROG_WORDS-1];   // Halt everywhere outside
        end
        return prog_mem[idx];
    endfunction

    function automatic xlen_t alu(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[5:0];
            3'b010:  return xlen_t'($signed(a) < $signed(b));
            3'b011:  return xlen_t'(a < b);
            3'b100:  return a ^ b;
            3'b101:  return alt ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic step_t execute_one(inst_t inst, xlen_t pc);
        step_t       s;
        xlen_t       a;
        xlen_t       b;
        xlen_t       imm_i;
        xlen_t       imm_u;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] w;
        logic        wr;
        logic        jump;
        a     = model_regs[inst[19:15]];
        b     = model_regs[inst[24:20]];
        f3    = inst[14:12];
        f7    = inst[31:25];
        imm_i = {{52{inst[31]}}, inst[31:20]};
        imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
        s     = '{rd: inst[11:7], value: '0, next_pc: pc + 64'd4};
        wr    = 1'b0;
        jump  = 1'b0;
        case (inst[6:0])
            OPC_OP: begin
                wr      = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
                s.value = alu(f3, f7[5], a, b);
            end
            OPC_OP_IMM: begin
                wr      = (f3 != 3'b001 && f3 != 3'b101) || f7[6:1] == 6'h00 ||
                          (f3 == 3'b101 && f7[6:1] == 6'h10);
                s.value = alu(f3, f3 == 3'b101 && f7[5], a, imm_i);
            end
            OPC_OP_32: begin
                wr      = f3 == 3'b000 && (f7 == 7'h00 || f7 == 7'h20);
                w       = f7[5] ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
                s.value = {{32{w[31]}}, w};
            end
            OPC_OP_IMM_32: begin
                wr      = f3 == 3'b000;
                w       = a[31:0] + imm_i[31:0];
                s.value = {{32{w[31]}}, w};
            end
            OPC_LUI: begin
                wr      = 1'b1;
                s.value = imm_u;
            end
            OPC_AUIPC: begin
                wr      = 1'b1;
                s.value = pc + imm_u;
            end
            OPC_JAL: begin
                wr        = 1'b1;
                s.value   = pc + 64'd4;
                s.next_pc = pc + {{43{inst[31]}}, inst[31], inst[19:12], inst[20],
                                  inst[30:21], 1'b0};
            end
            OPC_JALR: begin
                if (f3 == 3'b000) begin
                    wr        = 1'b1;
                    s.value   = pc + 64'd4;
                    s.next_pc = (a + imm_i) & ~64'd1;
                end
            end
            OPC_BRANCH: begin
                case (f3)
                    3'b000:  jump = a == b;
                    3'b001:  jump = a != b;
                    3'b100:  jump = $signed(a) < $signed(b);
                    3'b101:  jump = $signed(a) >= $signed(b);
                    3'b110:  jump = a < b;
                    3'b111:  jump = a >= b;
                    default: jump = 1'b0;
                endcase
                if (jump) begin
                    s.next_pc = pc + {{51{inst[31]}}, inst[31], inst[7], inst[30:25],
                                      inst[11:8], 1'b0};
                end
            end
            default: wr = 1'b0;   // Unknown encoding, plain no-op
        endcase
        if (!wr || s.rd == 5'd0) begin
            s.rd    = '0;
            s.value = '0;
        end
        return s;
    endfunction

    function automatic int differs(string name, xlen_t expected, xlen_t actual);
        if (expected !== actual) begin
            $display("ERROR %s at pc %h: expected %h, actual %h",
                     name, model_pc, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    initial begin
        done        = 1'b0;
        retired     = 0;
        pc_errors   = 0;
        rd_errors   = 0;
        data_errors = 0;
    end

    // Retire port is registered, so the falling edge sees it settled
    always @(negedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            model_pc = RESET_PC;
            done     = 1'b0;
        end else if (retire_valid && !done) begin
            retired     = retired + 1;
            exp_step    = execute_one(word_at(model_pc), model_pc);
            pc_errors   = pc_errors + differs("retire_pc", model_pc, retire_pc);
            rd_errors   = rd_errors + differs("retire_rd", xlen_t'(exp_step.rd),
                                              xlen_t'(retire_rd));
            data_errors = data_errors + differs("retire_data", exp_step.value, retire_data);
            if (exp_step.rd != 5'd0) begin
                model_regs[exp_step.rd] = exp_step.value;
            end
            if (model_pc == HALT_PC) begin
                done = 1'b1;
            end
            model_pc = exp_step.next_pc;
        end
    end

endmodule

`default_nettype wire

/* bench/core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module core_props (
    input logic              clk,
    input logic              rst_n,
    input logic              redirect,
    input logic              retire_valid,
    input rv_isa_pkg::xlen_t retire_pc
);

    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !retire_valid)
        else $error("retire_valid high while reset is asserted");

    // Fetch, decode and execute come before the first retirement
    quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !retire_valid [*3])
        else $error("retirement within three cycles of reset release");

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> retire_pc[1:0] == 2'b00)
        else $error("retired pc not 4-byte aligned");

    flush_bubbles: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> ##2 !retire_valid [*2])
        else $error("flushed slot retired after a redirect");

endmodule

bind rv_core_top core_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .redirect     (redirect),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc)
);

`default_nettype wire

/* bench/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb;
    import rv_isa_pkg::*;

    localparam int    PROG_WORDS = 200;
    localparam xlen_t RESET_PC   = 64'h0;
    localparam int    MAX_CYCLES = PROG_WORDS * 3 + 50;   // Every word a taken jump, plus margin

    logic      clk;
    logic      rst_n;
    xlen_t     imem_addr;
    inst_t     imem_data;
    logic      retire_valid;
    xlen_t     retire_pc;
    reg_addr_t retire_rd;
    xlen_t     retire_data;
    inst_t     prog_mem [PROG_WORDS];
    integer    seed;
    int        cycles;
    logic      check_done;
    int        retired;
    int        pc_errors;
    int        rd_errors;
    int        data_errors;

    rv_core_top #(
        .RESET_PC (RESET_PC)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    core_checker #(
        .PROG_WORDS (PROG_WORDS),
        .RESET_PC   (RESET_PC)
    ) u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .prog_mem     (prog_mem),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .done         (check_done),
        .retired      (retired),
        .pc_errors    (pc_errors),
        .rd_errors    (rd_errors),
        .data_errors  (data_errors)
    );

    function automatic inst_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     funct3_t f3, reg_addr_t rd, opcode_t op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic inst_t i_type(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
                                     reg_addr_t rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t jal_inst(logic [20:0] off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic inst_t branch_inst(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                          funct3_t f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    // Few registers, so neighbours often depend on each other
    function automatic reg_addr_t pick_reg();
        return reg_addr_t'($unsigned($random(seed)) % 8);
    endfunction

    function automatic inst_t fetch_word(xlen_t addr);
        xlen_t idx;
        idx = (addr - RESET_PC) >> 2;
        if (addr < RESET_PC || idx >= PROG_WORDS) begin
            return prog_mem[PROG_WORDS-1];
        end
        return prog_mem[idx];
    endfunction

    task automatic build_program();
        int          kind;
        int          tgt;
        logic [31:0] rnd;
        logic [6:0]  f7;
        logic [11:0] imm12;
        funct3_t     f3;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        for (int i = 0; i < PROG_WORDS - 1; i++) begin
            kind = $unsigned($random(seed)) % 13;
            rnd  = $random(seed);
            f3   = rnd[14:12];
            rd   = pick_reg();
            rs1  = pick_reg();
            rs2  = pick_reg();
            tgt  = i + 1 + $unsigned($random(seed)) % 6;   // Forward only
            if (tgt > PROG_WORDS - 1) begin
                tgt = PROG_WORDS - 1;
            end
            f7    = (rnd[30] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
            imm12 = rnd[31:20];
            if (f3 == 3'b001 || f3 == 3'b101) begin
                imm12 = {f7[6:1], rnd[25:20]};   // 6-bit shamt
            end
            case (kind)
                0, 1:    prog_mem[i] = r_type(f7, rs2, rs1, f3, rd, OPC_OP);
                2, 3:    prog_mem[i] = i_type(imm12, rs1, f3, rd, OPC_OP_IMM);
                4:       prog_mem[i] = r_type(rnd[30] ? 7'h20 : 7'h00, rs2, rs1, 3'b000, rd,
                                              OPC_OP_32);
                5:       prog_mem[i] = i_type(rnd[31:20], rs1, 3'b000, rd, OPC_OP_IMM_32);
                6:       prog_mem[i] = {rnd[31:12], rd, OPC_LUI};
                7:       prog_mem[i] = {rnd[31:12], rd, OPC_AUIPC};
                8:       prog_mem[i] = jal_inst(21'((tgt - i) * 4), rd);
                9:       prog_mem[i] = i_type(12'(RESET_PC + tgt * 4 + rnd[0]), 5'd0, 3'b000, rd,
                                              OPC_JALR);   // Odd target tests bit 0
                10, 11:  prog_mem[i] = branch_inst(13'((tgt - i) * 4), rs2, rs1, f3);
                default: prog_mem[i] = rnd[0] ? {rnd[31:15], 3'b001, rnd[11:7], OPC_OP_IMM_32}
                                              : {rnd[31:7], 7'b0000011};   // SLLIW or load
            endcase
        end
        prog_mem[PROG_WORDS-1] = jal_inst(21'd0, 5'd0);   // Halt loop
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Instruction memory answers 2 ns after the PC moves
    always @(posedge clk) begin
        #2;
        imem_data = fetch_word(imem_addr);
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycles <= cycles + 1;
        end
    end

    initial begin
        rst_n     = 1'b0;
        imem_data = NOP_INST;
        cycles    = 0;
        seed      = 32'hd391;
        build_program();
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
        while (!check_done && cycles < MAX_CYCLES) begin
            @(posedge clk);
        end
        $display("Retired %0d instructions: %0d pc errors, %0d rd errors, %0d data errors",
                 retired, pc_errors, rd_errors, data_errors);
        if (check_done && pc_errors + rd_errors + data_errors == 0) begin
            $display("** PASS **");
        end else begin
            if (!check_done) begin
                $display("Timeout: halt instruction did not retire within %0d cycles",
                         MAX_CYCLES);
            end
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
rtl/rv_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
rtl/register_file.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/rv_core_top.sv
bench/core_props.sv
bench/core_checker.sv
bench/core_tb.sv

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pipe_pkg::fetch_pkt_t  fetch_pkt,
    input  logic                  flush,
    output rv_isa_pkg::reg_addr_t rs1_addr,
    output rv_isa_pkg::reg_addr_t rs2_addr,
    input  rv_isa_pkg::xlen_t     rs1_data,
    input  rv_isa_pkg::xlen_t     rs2_data,
    output pipe_pkg::decode_pkt_t decode_pkt
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    inst_t       inst;
    opcode_t     opcode;
    funct3_t     funct3;
    logic [6:0]  funct7;
    xlen_t       imm_i;
    xlen_t       imm_u;
    xlen_t       imm_j;
    xlen_t       imm_b;
    logic        legal;
    decode_pkt_t dec;

    function automatic alu_op_e alu_from_f3(funct3_t f3, logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign inst   = fetch_pkt.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    always_comb begin
        dec         = '0;
        dec.valid   = fetch_pkt.valid;
        dec.pc      = fetch_pkt.pc;
        dec.rs1     = rs1_addr;
        dec.rs2     = rs2_addr;
        dec.rs1_val = rs1_data;
        dec.rs2_val = rs2_data;
        dec.rd      = inst[11:7];
        dec.funct3  = funct3;
        dec.alu_op  = ALU_ADD;
        dec.opa_sel = OPA_ZERO;
        dec.opb_sel = OPB_IMM;
        legal       = 1'b1;
        case (opcode)
            OPC_OP: begin
                legal       = (funct7 == 7'b0) ||
                              (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
                dec.we      = 1'b1;
                dec.opa_sel = OPA_REG;
                dec.opb_sel = OPB_REG;
                dec.alu_op  = alu_from_f3(funct3, inst[30]);
            end
            OPC_OP_IMM: begin
                if (funct3 == F3_SLL) begin
                    legal = (inst[31:26] == 6'b0);
                end else if (funct3 == F3_SR) begin
                    legal = (inst[31:26] == 6'b0) || (inst[31:26] == 6'b010000);
                end
                dec.we      = 1'b1;
                dec.opa_sel = OPA_REG;
                dec.imm     = imm_i;
                dec.alu_op  = alu_from_f3(funct3, (funct3 == F3_SR) && inst[30]);
            end
            OPC_OP_32: begin   // ADDW and SUBW only
                legal       = (funct3 == F3_ADD) && (funct7 == 7'b0 || funct7 == F7_ALT);
                dec.we      = 1'b1;
                dec.word_op = 1'b1;
                dec.opa_sel = OPA_REG;
                dec.opb_sel = OPB_REG;
                dec.alu_op  = inst[30] ? ALU_SUB : ALU_ADD;
            end
            OPC_OP_IMM_32: begin
                legal       = (funct3 == F3_ADD);
                dec.we      = 1'b1;
                dec.word_op = 1'b1;
                dec.opa_sel = OPA_REG;
                dec.imm     = imm_i;
            end
            OPC_LUI: begin
                dec.we     = 1'b1;
                dec.imm    = imm_u;
                dec.alu_op = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                dec.we      = 1'b1;
                dec.opa_sel = OPA_PC;
                dec.imm     = imm_u;
            end
            OPC_JAL: begin   // ALU gives the target, execute makes the link
                dec.we      = 1'b1;
                dec.jal     = 1'b1;
                dec.opa_sel = OPA_PC;
                dec.imm     = imm_j;
            end
            OPC_JALR: begin
                legal       = (funct3 == 3'b000);
                dec.we      = 1'b1;
                dec.jalr    = 1'b1;
                dec.opa_sel = OPA_REG;
                dec.imm     = imm_i;
            end
            OPC_BRANCH: begin
                legal       = (funct3 != 3'b010) && (funct3 != 3'b011);
                dec.branch  = 1'b1;
                dec.opa_sel = OPA_PC;
                dec.imm     = imm_b;
            end
            default: legal = 1'b0;
        endcase
        // Unknown encoding retires as a plain no-op
        if (!legal) begin
            dec.we     = 1'b0;
            dec.jal    = 1'b0;
            dec.jalr   = 1'b0;
            dec.branch = 1'b0;
        end
        if (dec.rd == '0) begin
            dec.we = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decode_pkt <= '0;
        end else begin
            decode_pkt       <= dec;
            decode_pkt.valid <= dec.valid & ~flush;
        end
    end

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pipe_pkg::decode_pkt_t decode_pkt,
    input  pipe_pkg::result_pkt_t fwd_pkt,
    output logic                  redirect,
    output rv_isa_pkg::xlen_t     redirect_pc,
    output pipe_pkg::result_pkt_t result_pkt
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    xlen_t       rs1_val;
    xlen_t       rs2_val;
    xlen_t       op_a;
    xlen_t       op_b;
    xlen_t       alu_out;
    word32_t     word_res;
    logic        taken;
    result_pkt_t res;

    function automatic xlen_t forward(reg_addr_t src, xlen_t val, result_pkt_t fwd);
        if (fwd.valid && fwd.we && fwd.rd != '0 && fwd.rd == src) begin
            return fwd.value;
        end
        return val;
    endfunction

    assign rs1_val = forward(decode_pkt.rs1, decode_pkt.rs1_val, fwd_pkt);
    assign rs2_val = forward(decode_pkt.rs2, decode_pkt.rs2_val, fwd_pkt);

    always_comb begin
        case (decode_pkt.opa_sel)
            OPA_REG: op_a = rs1_val;
            OPA_PC:  op_a = decode_pkt.pc;
            default: op_a = '0;
        endcase
        op_b = (decode_pkt.opb_sel == OPB_REG) ? rs2_val : decode_pkt.imm;
    end

    always_comb begin
        case (decode_pkt.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << op_b[5:0];
            ALU_SLT:    alu_out = {63'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {63'b0, op_a < op_b};
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> op_b[5:0];
            ALU_SRA:    alu_out = xlen_t'($signed(op_a) >>> op_b[5:0]);
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    assign word_res = alu_out[31:0];

    // Branch compare on forwarded sources
    always_comb begin
        case (decode_pkt.funct3)
            F3_BEQ:  taken = (rs1_val == rs2_val);
            F3_BNE:  taken = (rs1_val != rs2_val);
            F3_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
            F3_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            F3_BLTU: taken = (rs1_val < rs2_val);
            F3_BGEU: taken = (rs1_val >= rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign redirect = decode_pkt.valid &&
                      (decode_pkt.jal || decode_pkt.jalr || (decode_pkt.branch && taken));
    assign redirect_pc = {alu_out[63:1], 1'b0};   // Bit 0 cleared for JALR

    always_comb begin
        res.valid = decode_pkt.valid;
        res.pc    = decode_pkt.pc;
        res.rd    = decode_pkt.rd;
        res.we    = decode_pkt.we;
        if (decode_pkt.jal || decode_pkt.jalr) begin
            res.value = decode_pkt.pc + 64'd4;   // Link
        end else if (decode_pkt.word_op) begin
            res.value = {{32{word_res[31]}}, word_res};
        end else begin
            res.value = alu_out;
        end
    end

    assign result_pkt = res;

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter rv_isa_pkg::xlen_t RESET_PC = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 redirect,
    input  rv_isa_pkg::xlen_t    redirect_pc,
    output rv_isa_pkg::xlen_t    imem_addr,
    input  rv_isa_pkg::inst_t    imem_data,
    output pipe_pkg::fetch_pkt_t fetch_pkt
);
    import rv_isa_pkg::*;

    xlen_t pc;

    assign imem_addr = pc;   // Memory answers in the same cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= RESET_PC;
            fetch_pkt <= '{valid: 1'b0, pc: RESET_PC, inst: NOP_INST};
        end else begin
            pc              <= redirect ? redirect_pc : pc + 64'd4;
            // Wrong-path fetch dies here
            fetch_pkt.valid <= ~redirect;
            fetch_pkt.pc    <= pc;
            fetch_pkt.inst  <= imem_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {OPA_REG, OPA_PC, OPA_ZERO} opa_sel_e;
    typedef enum logic [0:0] {OPB_REG, OPB_IMM} opb_sel_e;

    typedef struct packed {
        logic              valid;
        rv_isa_pkg::xlen_t pc;
        rv_isa_pkg::inst_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::xlen_t     pc;
        rv_isa_pkg::reg_addr_t rs1;
        rv_isa_pkg::reg_addr_t rs2;
        rv_isa_pkg::xlen_t     rs1_val;
        rv_isa_pkg::xlen_t     rs2_val;
        rv_isa_pkg::reg_addr_t rd;
        logic                  we;
        rv_isa_pkg::xlen_t     imm;
        alu_op_e               alu_op;
        opa_sel_e              opa_sel;
        opb_sel_e              opb_sel;
        logic                  word_op;   // 32-bit op, result sign-extended
        logic                  jal;
        logic                  jalr;
        logic                  branch;
        rv_isa_pkg::funct3_t   funct3;
    } decode_pkt_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::xlen_t     pc;
        rv_isa_pkg::reg_addr_t rd;
        logic                  we;
        rv_isa_pkg::xlen_t     value;
    } result_pkt_t;

endpackage

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_isa_pkg::reg_addr_t rs1_addr,
    input  rv_isa_pkg::reg_addr_t rs2_addr,
    output rv_isa_pkg::xlen_t     rs1_data,
    output rv_isa_pkg::xlen_t     rs2_data,
    input  logic                  wr_en,
    input  rv_isa_pkg::reg_addr_t wr_addr,
    input  rv_isa_pkg::xlen_t     wr_data
);
    import rv_isa_pkg::*;

    xlen_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through covers the instruction two behind the writer
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (wr_en && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (wr_en && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule

`default_nettype wire

/* rtl/result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pipe_pkg::result_pkt_t result_pkt,
    output logic                  wr_en,
    output rv_isa_pkg::reg_addr_t wr_addr,
    output rv_isa_pkg::xlen_t     wr_data,
    output pipe_pkg::result_pkt_t fwd_pkt,
    output logic                  retire_valid,
    output rv_isa_pkg::xlen_t     retire_pc,
    output rv_isa_pkg::reg_addr_t retire_rd,
    output rv_isa_pkg::xlen_t     retire_data
);
    import pipe_pkg::*;

    result_pkt_t res_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_q <= '0;
        end else begin
            res_q <= result_pkt;
        end
    end

    assign wr_en   = res_q.valid & res_q.we;
    assign wr_addr = res_q.rd;
    assign wr_data = res_q.value;
    assign fwd_pkt = res_q;   // Execute checks valid and we itself

    // One cycle per instruction, rd and data zero when nothing is written
    assign retire_valid = res_q.valid;
    assign retire_pc    = res_q.pc;
    assign retire_rd    = wr_en ? res_q.rd : '0;
    assign retire_data  = wr_en ? res_q.value : '0;

endmodule

`default_nettype wire

/* rtl/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
    parameter rv_isa_pkg::xlen_t RESET_PC = 64'h0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    output rv_isa_pkg::xlen_t     imem_addr,
    input  rv_isa_pkg::inst_t     imem_data,
    output logic                  retire_valid,
    output rv_isa_pkg::xlen_t     retire_pc,
    output rv_isa_pkg::reg_addr_t retire_rd,
    output rv_isa_pkg::xlen_t     retire_data
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    fetch_pkt_t  fetch_pkt;
    decode_pkt_t decode_pkt;
    result_pkt_t exec_pkt;
    result_pkt_t fwd_pkt;
    logic        redirect;
    xlen_t       redirect_pc;
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    xlen_t       rs1_data;
    xlen_t       rs2_data;
    logic        wr_en;
    reg_addr_t   wr_addr;
    xlen_t       wr_data;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .fetch_pkt   (fetch_pkt)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_pkt  (fetch_pkt),
        .flush      (redirect),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .decode_pkt (decode_pkt)
    );

    register_file u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .decode_pkt  (decode_pkt),
        .fwd_pkt     (fwd_pkt),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .result_pkt  (exec_pkt)
    );

    result_stage u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .result_pkt   (exec_pkt),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .fwd_pkt      (fwd_pkt),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

`default_nettype wire

/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     word32_t;   // W-op intermediate
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;

    // Major opcodes
    localparam opcode_t OPC_OP        = 7'b0110011;
    localparam opcode_t OPC_OP_IMM    = 7'b0010011;
    localparam opcode_t OPC_OP_32     = 7'b0111011;
    localparam opcode_t OPC_OP_IMM_32 = 7'b0011011;
    localparam opcode_t OPC_LUI       = 7'b0110111;
    localparam opcode_t OPC_AUIPC     = 7'b0010111;
    localparam opcode_t OPC_JAL       = 7'b1101111;
    localparam opcode_t OPC_JALR      = 7'b1100111;
    localparam opcode_t OPC_BRANCH    = 7'b1100011;

    // ALU funct3
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;   // SRL and SRA
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // Branch funct3
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000;   // SUB, SRA

    localparam inst_t NOP_INST = 32'h0000_0013;   // addi x0,x0,0

endpackage

`default_nettype wire
